// ==== bench/tb_checker.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_checker (
	input  logic                      clk,
	input  logic                      rst,
	input  mem_op_pkg::mem_op_t       mem_op,
	input  logic [`MEM_ADDR_BITS-1:0] mem_addr,
	input  logic [31:0]               mem_wdata,
	input  logic [3:0]                mem_byte_sel,
	input  logic [31:0]               mem_rdata,
	input  logic                      mem_rdy,
	input  logic                      ram_read,
	input  logic                      ram_write,
	input  logic                      ram_done,
	input  logic [127:0]              test_name,
	input  logic                      exp_hit,
	input  logic                      closing,
	output logic                      busy,
	output logic                      closed,
	output int                        n_tests,
	output int                        n_errors
);
	import mem_op_pkg::*;

	localparam int MEM_WORDS = 1 << `MEM_ADDR_BITS;

	// word image of what memory plus cache should hold
	logic [31:0] shadow [MEM_WORDS];
	// pending read
	logic [31:0] exp_word;
	logic [127:0] rd_name;
	logic [`MEM_ADDR_BITS-1:0] rd_addr;
	logic rd_hit;
	// cycles since the read was issued
	int rd_wait;
	// accepted writes not yet completed in memory
	int wr_pend;
	// one memory operation in flight
	logic mem_open;
	logic open_wr;
	// mem_rdy low with no read pending
	logic stall_seen;

	always @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				shadow[w] = 32'h5A000000 + w;
			end
			busy = 1'b0;
			closed = 1'b0;
			mem_open = 1'b0;
			open_wr = 1'b0;
			stall_seen = 1'b0;
			rd_wait = 0;
			wr_pend = 0;
			n_tests = 0;
			n_errors = 0;
		end else begin
			// --------------------------------------------------
			// memory port protocol
			// --------------------------------------------------
			if (ram_read && ram_write) begin
				$display("ram_read and ram_write were high in the same cycle");
				n_errors++;
			end
			if (ram_done) begin
				// a finished write has left the buffer
				if (mem_open && open_wr) wr_pend--;
				mem_open = 1'b0;
			end
			if (ram_read || ram_write) begin
				if (mem_open) begin
					$display("memory request issued while another was still outstanding");
					n_errors++;
				end
				if (ram_read && wr_pend != 0) begin
					$display("miss read issued while %0d buffered writes were not in memory",
						wr_pend);
					n_errors++;
				end
				mem_open = 1'b1;
				open_wr = ram_write;
			end
			if (!mem_rdy && !busy) stall_seen = 1'b1;

			// first ready cycle after issue, hit or end of miss
			if (busy) rd_wait++;
			if (busy && mem_rdy) begin
				n_tests++;
				if (mem_rdata !== exp_word) begin
					$display("[FAIL] %0s: expected %08h, actual %08h at %03h",
						rd_name, exp_word, mem_rdata, rd_addr);
					n_errors++;
				end else if (rd_hit && rd_wait != 1) begin
					$display("%0s: read at %03h should hit but took %0d cycles",
						rd_name, rd_addr, rd_wait);
					n_errors++;
				end else if (!rd_hit && rd_wait == 1) begin
					$display("%0s: read at %03h should miss but answered in one cycle",
						rd_name, rd_addr);
					n_errors++;
				end else begin
					$display("[PASS] %0s: read %03h = %08h", rd_name, rd_addr, mem_rdata);
				end
				busy = 1'b0;
			end

			// --------------------------------------------------
			// accepted host operations
			// --------------------------------------------------
			if (mem_rdy && mem_op == WRITE) begin
				for (int b = 0; b < 4; b++) begin
					if (mem_byte_sel[b]) shadow[mem_addr][8 * b +: 8] = mem_wdata[8 * b +: 8];
				end
				wr_pend++;
				n_tests++;
				$display("[DONE] %0s: write %03h sel %h", test_name, mem_addr, mem_byte_sel);
			end else if (mem_rdy && mem_op == READ) begin
				// expected value frozen at issue
				exp_word = shadow[mem_addr];
				rd_name = test_name;
				rd_addr = mem_addr;
				rd_hit = exp_hit;
				rd_wait = 0;
				busy = 1'b1;
			end

			if (closing && !closed) begin
				if (!stall_seen) begin
					$display("mem_rdy never dropped during the write burst");
					n_errors++;
				end
				closed = 1'b1;
			end
		end
	end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_top;
	import mem_op_pkg::*;
	import cache_pkg::*;

	// slowest memory answer, also the random range
	localparam int MAX_LAT = 8;
	localparam int MEM_WORDS = 1 << `MEM_ADDR_BITS;

	// one stimulus row, lat 0 means random
	// hit is the expected lookup result of a read
	typedef struct packed {
		logic [127:0] name;
		mem_op_t op;
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic [31:0] data;
		logic [3:0] sel;
		int lat;
		logic hit;
	} row_t;

	logic clk;
	logic rst;
	mem_op_t mem_op;
	host_addr_u mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_byte_sel;
	logic [31:0] mem_rdata;
	logic mem_rdy;
	logic ram_read;
	logic ram_write;
	logic [`MEM_LINE_ADDR_BITS-1:0] ram_addr;
	cache_line_u ram_wdata;
	byte_en_t ram_wmask;
	cache_line_u ram_rdata = '0;
	logic ram_done = 1'b0;

	row_t rows[$];
	logic [127:0] cur_name;
	logic cur_hit;
	int row_lat;
	// latency of the last accepted row
	int act_lat = 1;
	logic rows_ready;
	logic closing;
	logic closed;
	logic chk_busy;
	int n_tests;
	int n_errors;
	int seed = 21;

	// memory model state
	logic [31:0] mem_words [MEM_WORDS];
	int op_wait;
	logic op_read;
	logic [`MEM_LINE_ADDR_BITS-1:0] op_addr;
	cache_line_u op_data;
	byte_en_t op_mask;

	mem_cache_top mem_cache_top_i (
		.clk          (clk),
		.rst          (rst),
		.mem_op       (mem_op),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_byte_sel (mem_byte_sel),
		.mem_rdata    (mem_rdata),
		.mem_rdy      (mem_rdy),
		.ram_read     (ram_read),
		.ram_write    (ram_write),
		.ram_addr     (ram_addr),
		.ram_wdata    (ram_wdata),
		.ram_wmask    (ram_wmask),
		.ram_rdata    (ram_rdata),
		.ram_done     (ram_done)
	);

	tb_checker tb_checker_i (
		.clk          (clk),
		.rst          (rst),
		.mem_op       (mem_op),
		.mem_addr     (mem_addr.flat),
		.mem_wdata    (mem_wdata),
		.mem_byte_sel (mem_byte_sel),
		.mem_rdata    (mem_rdata),
		.mem_rdy      (mem_rdy),
		.ram_read     (ram_read),
		.ram_write    (ram_write),
		.ram_done     (ram_done),
		.test_name    (cur_name),
		.exp_hit      (cur_hit),
		.closing      (closing),
		.busy         (chk_busy),
		.closed       (closed),
		.n_tests      (n_tests),
		.n_errors     (n_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// memory model
	// --------------------------------------------------
	// strobes only depend on DUT state, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				mem_words[w] = 32'h5A000000 + w;
			end
			op_wait = 0;
			ram_done <= 1'b0;
		end else begin
			ram_done <= 1'b0;
			if (op_wait > 0) begin
				op_wait = op_wait - 1;
				if (op_wait == 0) begin
					ram_done <= 1'b1;
					if (op_read) begin
						for (int i = 0; i < `MEM_LINE_WORDS; i++) begin
							ram_rdata.lane[i] <= mem_words[op_addr * 4 + i];
						end
					end else begin
						// only enabled bytes land
						for (int k = 0; k < `MEM_LINE_BYTES; k++) begin
							if (op_mask[k]) begin
								mem_words[op_addr * 4 + k / 4][8 * (k % 4) +: 8] =
									op_data.flat[8 * k +: 8];
							end
						end
					end
				end
			end else if (ram_read || ram_write) begin
				op_read = ram_read;
				op_addr = ram_addr;
				op_data = ram_wdata;
				op_mask = ram_wmask;
				if (act_lat == 0) begin
					op_wait = ($random(seed) & 7) + 1;
				end else begin
					op_wait = act_lat;
				end
			end
		end
	end

	// row latency takes effect once the row is accepted
	always @(posedge clk) begin
		if (mem_rdy && (mem_op == WRITE || mem_op == READ)) begin
			act_lat <= row_lat;
		end
	end

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------
	task automatic add_row(input logic [127:0] name, input mem_op_t op,
			input logic [`MEM_ADDR_BITS-1:0] addr, input logic [31:0] data,
			input logic [3:0] sel, input int lat, input logic hit);
		row_t r;
		r.name = name;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.sel = sel;
		r.lat = lat;
		r.hit = hit;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// untouched word, straight from the memory image
		add_row("miss_init", READ, 12'h123, 32'h0, 4'hF, 2, 1'b0);
		// write then hit on the same word
		add_row("wr_full", WRITE, 12'h210, 32'hDEADBEEF, 4'hF, 1, 1'b0);
		add_row("rd_hit", READ, 12'h210, 32'h0, 4'hF, 1, 1'b1);
		// bytes 0 and 2 only, line not cached
		add_row("wr_part", WRITE, 12'h305, 32'h11223344, 4'b0101, 3, 1'b0);
		add_row("rd_merge", READ, 12'h305, 32'h0, 4'hF, 3, 1'b0);
		// set 6, tag 1 written, tag 9 evicts it
		add_row("wr_conf_a", WRITE, 12'h058, 32'hA5A50001, 4'hF, 4, 1'b0);
		add_row("wr_conf_b", WRITE, 12'h059, 32'hA5A50002, 4'b0011, 4, 1'b0);
		add_row("rd_conf", READ, 12'h258, 32'h0, 4'hF, 5, 1'b0);
		add_row("rd_back_a", READ, 12'h058, 32'h0, 4'hF, 2, 1'b0);
		// the fill of rd_back_a brought the whole line in
		add_row("rd_back_b", READ, 12'h059, 32'h0, 4'hF, 2, 1'b1);
		// burst into one set, more writes than buffer entries
		for (int i = 0; i < 20; i++) begin
			add_row("burst_wr", WRITE, 12'(8 + i * 64), 32'hC0DE0000 + i, 4'hF, MAX_LAT, 1'b0);
		end
		// each read evicts the tag before it, so all miss
		for (int i = 0; i < 20; i++) begin
			add_row("burst_rd", READ, 12'(8 + i * 64), 32'h0, 4'hF, 0, 1'b0);
		end
	endtask

	initial begin
		mem_op = NOOP;
		mem_addr = '0;
		mem_wdata = '0;
		mem_byte_sel = '0;
		cur_name = '0;
		cur_hit = 1'b0;
		row_lat = 1;
		closing = 1'b0;
		rows_ready = 1'b0;
		rst = 1'b1;
		build_table();
		rows_ready = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (rows[i]) begin
			@(negedge clk);
			// idle while stalled so nothing repeats
			mem_op = NOOP;
			while (!mem_rdy) @(negedge clk);
			cur_name = rows[i].name;
			cur_hit = rows[i].hit;
			mem_op = rows[i].op;
			mem_addr.flat = rows[i].addr;
			mem_wdata = rows[i].data;
			mem_byte_sel = rows[i].sel;
			row_lat = rows[i].lat;
		end
		@(negedge clk);
		mem_op = NOOP;
		while (chk_busy || !mem_rdy) @(negedge clk);
		closing = 1'b1;
		while (!closed) @(negedge clk);
		$display("tests run %0d, errors %0d", n_tests, n_errors);
		if (n_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// run limit scales with the table
	initial begin
		int limit;
		wait (rows_ready);
		limit = 16 + rows.size() * (MAX_LAT + 40);
		repeat (limit) @(posedge clk);
		$display("timeout, run did not finish within %0d cycles", limit);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== include/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// --------------------------------------------------
// line geometry
// --------------------------------------------------
// 32-bit words per line
`define MEM_LINE_WORDS 4
`define MEM_LINE_BITS 128
// one enable per byte of the line
`define MEM_LINE_BYTES 16

// --------------------------------------------------
// cache, buffer and address sizes
// --------------------------------------------------
`define MEM_SET_COUNT 16
`define MEM_BUF_DEPTH 16
// host word address, tag:set:lane
`define MEM_ADDR_BITS 12
`define MEM_LANE_BITS 2
`define MEM_SET_BITS 4
`define MEM_TAG_BITS 6
// word address without the lane bits
`define MEM_LINE_ADDR_BITS 10

`endif

// ==== rtl/cache_pkg.sv ====
`include "mem_consts.svh"

// --------------------------------------------------
// line and address views
// --------------------------------------------------
package cache_pkg;

	// one line word
	// flat for masking and transfer, lanes for word access
	// lane 0 sits in the low 32 bits
	typedef union packed {
		logic [`MEM_LINE_BITS-1:0] flat;
		logic [`MEM_LINE_WORDS-1:0][31:0] lane;
	} cache_line_u;

	// host word address
	// line address is tag and set together
	typedef union packed {
		logic [`MEM_ADDR_BITS-1:0] flat;
		struct packed {
			// compared against the stored tag
			logic [`MEM_TAG_BITS-1:0] tag;
			// direct-mapped index
			logic [`MEM_SET_BITS-1:0] set;
			// word within the line
			logic [`MEM_LANE_BITS-1:0] lane;
		} fields;
	} host_addr_u;

	// per byte of a line
	// high when written, or held valid in the cache
	typedef logic [`MEM_LINE_BYTES-1:0] byte_en_t;

endpackage

// ==== rtl/cache_store.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module cache_store (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::host_addr_u  look_addr,
	input  cache_pkg::host_addr_u  miss_addr,
	input  logic                   fill_active,
	input  logic                   wr_en,
	input  cache_pkg::cache_line_u new_data,
	input  cache_pkg::byte_en_t    new_mask,
	input  cache_pkg::cache_line_u ram_rdata,
	input  logic                   ram_done,
	output cache_pkg::cache_line_u line_out,
	output logic                   hit,
	output cache_pkg::host_addr_u  sel_addr
);
	import cache_pkg::*;

	// per set arrays, direct mapped
	logic [`MEM_TAG_BITS-1:0] tag_mem [`MEM_SET_COUNT];
	cache_line_u data_mem [`MEM_SET_COUNT];
	byte_en_t valid_mem [`MEM_SET_COUNT];

	logic [`MEM_SET_BITS-1:0] set_idx;
	logic tag_match;
	byte_en_t cur_valid;
	cache_line_u cur_line;
	cache_line_u host_line;
	cache_line_u fill_line;
	logic [`MEM_LINE_BITS-1:0] new_bits;
	logic [`MEM_LINE_BITS-1:0] held_bits;
	logic fill_we;

	// byte enables widened to a bit mask
	function automatic logic [`MEM_LINE_BITS-1:0] expand(input byte_en_t en);
		logic [`MEM_LINE_BITS-1:0] m;
		for (int i = 0; i < `MEM_LINE_BYTES; i++) begin
			m[8*i +: 8] = {8{en[i]}};
		end
		return m;
	endfunction

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------
	// miss address owns the arrays while a fill is pending
	assign sel_addr = fill_active ? miss_addr : look_addr;
	assign set_idx = sel_addr.fields.set;
	assign cur_line = data_mem[set_idx];
	assign tag_match = (tag_mem[set_idx] == sel_addr.fields.tag);
	// flags of another tag count as nothing held
	assign cur_valid = tag_match ? valid_mem[set_idx] : '0;
	// every selected byte must already be held
	assign hit = tag_match && ((new_mask & ~cur_valid) == '0);

	// --------------------------------------------------
	// merges
	// --------------------------------------------------
	assign new_bits = expand(new_mask);
	assign held_bits = expand(cur_valid);
	// host bytes over the current line
	assign host_line.flat = (cur_line.flat & ~new_bits) | (new_data.flat & new_bits);
	// fetched bytes only under bytes not yet held
	assign fill_line.flat = (ram_rdata.flat & ~held_bits) | (cur_line.flat & held_bits);
	// read path sees the merged line during the fill
	assign line_out = fill_active ? fill_line : cur_line;
	assign fill_we = fill_active && ram_done;

	always_ff @(posedge clk) begin
		if (fill_we) begin
			data_mem[set_idx] <= fill_line;
			tag_mem[set_idx] <= sel_addr.fields.tag;
		end else if (wr_en) begin
			data_mem[set_idx] <= host_line;
			tag_mem[set_idx] <= sel_addr.fields.tag;
		end
	end

	// byte-valid flags
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MEM_SET_COUNT; i++) begin
				valid_mem[i] <= '0;
			end
		end else if (fill_we) begin
			// whole line held after a fill
			valid_mem[set_idx] <= '1;
		end else if (wr_en) begin
			valid_mem[set_idx] <= cur_valid | new_mask;
		end
	end

	// host is stalled for the whole miss, so no write meets a fill
	a_wr_not_fill: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !fill_active);

endmodule

// ==== rtl/lane_align.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module lane_align (
	input  cache_pkg::host_addr_u  addr,
	input  logic [31:0]            wdata,
	input  logic [3:0]             byte_sel,
	input  cache_pkg::cache_line_u line_in,
	output cache_pkg::cache_line_u line_data,
	output cache_pkg::byte_en_t    line_mask,
	output logic [31:0]            word_out
);

	// --------------------------------------------------
	// word into line
	// --------------------------------------------------
	always_comb begin
		// other lanes stay zero and unselected
		line_data.flat = '0;
		line_mask = '0;
		for (int i = 0; i < `MEM_LINE_WORDS; i++) begin
			if (addr.fields.lane == i) begin
				line_data.lane[i] = wdata;
				// four byte enables per lane
				line_mask[4*i +: 4] = byte_sel;
			end
		end
	end

	// --------------------------------------------------
	// line to word
	// --------------------------------------------------
	// addressed lane of the incoming line
	assign word_out = line_in.lane[addr.fields.lane];

endmodule

// ==== rtl/mem_cache_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_cache_top (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_op_pkg::mem_op_t      mem_op,
	input  cache_pkg::host_addr_u    mem_addr,
	input  logic [31:0]              mem_wdata,
	input  logic [3:0]               mem_byte_sel,
	output logic [31:0]              mem_rdata,
	output logic                     mem_rdy,
	output logic                     ram_read,
	output logic                     ram_write,
	output logic [`MEM_LINE_ADDR_BITS-1:0] ram_addr,
	output cache_pkg::cache_line_u   ram_wdata,
	output cache_pkg::byte_en_t      ram_wmask,
	input  cache_pkg::cache_line_u   ram_rdata,
	input  logic                     ram_done
);
	import cache_pkg::*;

	// --------------------------------------------------
	// internal wires
	// --------------------------------------------------
	logic hit;
	logic buf_empty;
	logic buf_full;
	logic buf_full_next;
	logic buf_push;
	logic buf_pop;
	logic fill_active;
	logic [31:0] host_word;
	logic [`MEM_LINE_ADDR_BITS-1:0] head_addr;
	// saved on a miss, and the address the cache looks at
	host_addr_u miss_addr;
	host_addr_u sel_addr;
	// host word steered into its line position
	cache_line_u line_data;
	byte_en_t line_mask;
	// cache line at sel_addr, merged fill line during a fill
	cache_line_u line_out;

	// sequencing for host and memory
	mem_ctrl mem_ctrl_i (
		.clk           (clk),
		.rst           (rst),
		.mem_op        (mem_op),
		.mem_addr      (mem_addr),
		.hit           (hit),
		.buf_empty     (buf_empty),
		.buf_full_next (buf_full_next),
		.buf_full      (buf_full),
		.head_addr     (head_addr),
		.ram_done      (ram_done),
		.host_word     (host_word),
		.mem_rdy       (mem_rdy),
		.mem_rdata     (mem_rdata),
		.miss_addr     (miss_addr),
		.fill_active   (fill_active),
		.buf_push      (buf_push),
		.buf_pop       (buf_pop),
		.ram_read      (ram_read),
		.ram_write     (ram_write),
		.ram_addr      (ram_addr)
	);

	// pending line writes, head goes straight to memory
	write_buffer write_buffer_i (
		.clk       (clk),
		.rst       (rst),
		.push      (buf_push),
		.push_addr (mem_addr.flat[`MEM_ADDR_BITS-1:`MEM_LANE_BITS]),
		.push_data (line_data),
		.push_mask (line_mask),
		.pop       (buf_pop),
		.head_addr (head_addr),
		.head_data (ram_wdata),
		.head_mask (ram_wmask),
		.empty     (buf_empty),
		.full      (buf_full),
		.full_next (buf_full_next)
	);

	cache_store cache_store_i (
		.clk         (clk),
		.rst         (rst),
		.look_addr   (mem_addr),
		.miss_addr   (miss_addr),
		.fill_active (fill_active),
		.wr_en       (buf_push),
		.new_data    (line_data),
		.new_mask    (line_mask),
		.ram_rdata   (ram_rdata),
		.ram_done    (ram_done),
		.line_out    (line_out),
		.hit         (hit),
		.sel_addr    (sel_addr)
	);

	lane_align lane_align_i (
		.addr      (sel_addr),
		.wdata     (mem_wdata),
		.byte_sel  (mem_byte_sel),
		.line_in   (line_out),
		.line_data (line_data),
		.line_mask (line_mask),
		.word_out  (host_word)
	);

endmodule

// ==== rtl/mem_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  mem_op_pkg::mem_op_t   mem_op,
	input  cache_pkg::host_addr_u mem_addr,
	input  logic                  hit,
	input  logic                  buf_empty,
	input  logic                  buf_full_next,
	input  logic                  buf_full,
	input  logic [`MEM_LINE_ADDR_BITS-1:0] head_addr,
	input  logic                  ram_done,
	input  logic [31:0]           host_word,
	output logic                  mem_rdy,
	output logic [31:0]           mem_rdata,
	output cache_pkg::host_addr_u miss_addr,
	output logic                  fill_active,
	output logic                  buf_push,
	output logic                  buf_pop,
	output logic                  ram_read,
	output logic                  ram_write,
	output logic [`MEM_LINE_ADDR_BITS-1:0] ram_addr
);
	import mem_op_pkg::*;

	// one-hot phase
	// idle: no miss, memory free
	// writing: background drain write in flight
	// draining: miss waits, buffer empties first
	// reading: miss line read in flight
	localparam logic [3:0] S_IDLE = 4'b0001;
	localparam logic [3:0] S_WRITING = 4'b0010;
	localparam logic [3:0] S_DRAINING = 4'b0100;
	localparam logic [3:0] S_READING = 4'b1000;

	logic [3:0] st;
	// one memory operation outstanding
	logic ram_busy;
	logic wr_req;
	logic rd_req;
	logic miss_req;
	logic miss_pend;

	// --------------------------------------------------
	// host request decode
	// --------------------------------------------------
	assign wr_req = mem_rdy && (mem_op == WRITE);
	assign rd_req = mem_rdy && (mem_op == READ);
	assign miss_req = rd_req && !hit;
	assign miss_pend = (st == S_DRAINING) || (st == S_READING);

	// write goes to cache and buffer at the same edge
	assign buf_push = wr_req;

	// --------------------------------------------------
	// memory strobes
	// --------------------------------------------------
	// head entry out whenever memory is free and no read is in flight
	assign ram_write = !ram_busy && !buf_empty && ((st == S_IDLE) || (st == S_DRAINING));
	// miss read only once every buffered write has landed
	assign ram_read = (st == S_DRAINING) && !ram_busy && buf_empty;
	// entry leaves the buffer when its write completes
	assign buf_pop = ram_busy && ram_done && ((st == S_WRITING) || (st == S_DRAINING));
	assign fill_active = (st == S_READING);
	assign ram_addr = ram_read ? miss_addr.flat[`MEM_ADDR_BITS-1:`MEM_LANE_BITS] : head_addr;

	// phase and busy tracking
	always_ff @(posedge clk) begin
		if (rst) begin
			st <= S_IDLE;
			ram_busy <= 1'b0;
		end else begin
			if (ram_write || ram_read) begin
				ram_busy <= 1'b1;
			end else if (ram_done) begin
				ram_busy <= 1'b0;
			end
			unique case (st)
				S_IDLE: begin
					if (miss_req) begin
						st <= S_DRAINING;
					end else if (ram_write) begin
						st <= S_WRITING;
					end
				end
				S_WRITING: begin
					// a miss keeps the write in flight, now as a drain
					if (miss_req) begin
						st <= S_DRAINING;
					end else if (ram_done) begin
						st <= S_IDLE;
					end
				end
				S_DRAINING: begin
					if (ram_read) begin
						st <= S_READING;
					end
				end
				S_READING: begin
					if (ram_done) begin
						st <= S_IDLE;
					end
				end
				default: st <= S_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// host ready
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_rdy <= 1'b1;
		end else if (mem_rdy) begin
			// miss stalls, as does the push that fills the buffer
			if (miss_req) begin
				mem_rdy <= 1'b0;
			end else if (wr_req && buf_full_next && !buf_pop) begin
				mem_rdy <= 1'b0;
			end
		end else if ((st == S_READING) && ram_done) begin
			mem_rdy <= 1'b1;
		end else if (!miss_pend && (!buf_full || buf_pop)) begin
			mem_rdy <= 1'b1;
		end
	end

	// read word, from a hit or from the merged fill line
	always_ff @(posedge clk) begin
		if (rd_req && hit) begin
			mem_rdata <= host_word;
		end else if ((st == S_READING) && ram_done) begin
			mem_rdata <= host_word;
		end
	end

	// miss address held for the drain and the fetch
	always_ff @(posedge clk) begin
		if (miss_req) begin
			miss_addr <= mem_addr;
		end
	end

	// one strobe at a time
	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(ram_read && ram_write));
	// memory answers only the operation in flight
	a_done_busy: assert property (@(posedge clk) disable iff (rst)
		ram_done |-> ram_busy);

endmodule

// ==== rtl/mem_op_pkg.sv ====
// --------------------------------------------------
// host side operation codes
// --------------------------------------------------
package mem_op_pkg;

	// one operation per cycle while mem_rdy is high
	// code 3 is reserved and decodes as no operation
	typedef enum logic [1:0] {
		// nothing issued
		NOOP = 2'd0,
		// word write under byte selects
		WRITE = 2'd1,
		// word read, hit or miss
		READ = 2'd2
	} mem_op_t;

endpackage

// ==== rtl/write_buffer.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module write_buffer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  logic [`MEM_LINE_ADDR_BITS-1:0] push_addr,
	input  cache_pkg::cache_line_u push_data,
	input  cache_pkg::byte_en_t    push_mask,
	input  logic                   pop,
	output logic [`MEM_LINE_ADDR_BITS-1:0] head_addr,
	output cache_pkg::cache_line_u head_data,
	output cache_pkg::byte_en_t    head_mask,
	output logic                   empty,
	output logic                   full,
	output logic                   full_next
);
	import cache_pkg::*;

	localparam int PTR_BITS = $clog2(`MEM_BUF_DEPTH);

	// entry storage
	logic [`MEM_LINE_ADDR_BITS-1:0] addr_mem [`MEM_BUF_DEPTH];
	cache_line_u data_mem [`MEM_BUF_DEPTH];
	byte_en_t mask_mem [`MEM_BUF_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	// one bit wider than the pointers, reaches depth
	logic [PTR_BITS:0] usage;

	// --------------------------------------------------
	// pointers and usage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			usage <= '0;
		end else begin
			// pointers wrap at depth
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: usage <= usage + 1'b1;
				2'b01: usage <= usage - 1'b1;
				default: usage <= usage;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
			mask_mem[wr_ptr] <= push_mask;
		end
	end

	// oldest entry, presented to the memory port
	assign head_addr = addr_mem[rd_ptr];
	assign head_data = data_mem[rd_ptr];
	assign head_mask = mask_mem[rd_ptr];
	assign empty = (usage == '0);
	assign full = (usage == `MEM_BUF_DEPTH);
	assign full_next = (usage == `MEM_BUF_DEPTH - 1);

	// host ready and drain sequencing keep these from happening
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-f src.f -o tb_top_sim > build.log 2>&1 \
	&& ./obj_dir/tb_top_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Finished with errors" sim.log \
	&& { echo "simulation FAILED"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// ==== src.f ====
+incdir+include
rtl/mem_op_pkg.sv
rtl/cache_pkg.sv
rtl/lane_align.sv
rtl/write_buffer.sv
rtl/cache_store.sv
rtl/mem_ctrl.sv
rtl/mem_cache_top.sv
bench/tb_checker.sv
bench/tb_top.sv
